/* test/hwpe_regfile_testdata.txt */
# Columns, all hex: group op a b c
# op 1 write a=addr b=be c=data, 2 read a=addr b=expected, 3 events a={done,full,crit,run,ptr}
# op 4 idle a=cycles, 5 clear, 6 check io_params_o[a] against b
1 2 00 00000000 0
1 2 00 00000001 0
1 2 00 00000002 0
2 3 10 0 0
2 2 00 FFFFFFFE 0
2 4 1 0 0
2 3 20 0 0
2 2 00 FFFFFFFF 0
2 4 1 0 0
2 3 00 0 0
2 2 00 00000003 0
3 3 40 0 0
3 3 40 0 0
3 3 40 0 0
3 2 02 00000002 0
3 2 02 00000000 0
3 2 04 00000003 0
4 3 01 0 0
4 1 00 F 00000000
4 2 03 00000100 0
4 3 44 0 0
4 2 03 00000000 0
5 1 10 F 11111111
5 1 30 F 22222222
5 1 31 F 33333333
5 1 31 3 0000ABCD
5 1 31 4 00EE0000
5 1 29 F 00000055
5 2 10 11111111 0
5 2 30 22222222 0
5 2 31 33EEABCD 0
5 2 09 00000055 0
5 2 15 DEADBEEF 0
5 3 04 0 0
5 6 1 33EEABCD 0
6 5 0 0 0
6 2 00 00000000 0
6 2 02 00000000 0
6 2 04 00000000 0
6 2 31 00000000 0
6 6 1 00000000 0

/* hwpe_regfile.f */
design/hwpe_regfile_pkg.sv
design/regfile_addr_decode.sv
design/job_tracker.sv
design/param_bank.sv
design/read_mux.sv
design/hwpe_regfile_top.sv
test/hwpe_regfile_assertions.sv
test/tb_hwpe_regfile.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --assert -Wno-fatal
TOP       = tb_hwpe_regfile
FILELIST  = hwpe_regfile.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(OBJDIR)

/* test/tb_hwpe_regfile.sv */
// Testbench for the HWPE control register file
// Replays the operations of the test data file, checks each read response,
// the running context's parameters and the generic parameters

`timescale 1ns/100ps

module tb_hwpe_regfile;

  localparam int unsigned CYCLES_PER_OP = 20;
  localparam int unsigned DW            = hwpe_regfile_pkg::DATA_W;

  logic                           clk_i = 1'b0;
  logic                           rst_ni;
  logic                           clear_i;
  hwpe_regfile_pkg::regfile_req_t req_i;
  hwpe_regfile_pkg::job_events_t  events_i;
  logic                           rvalid_o;
  logic [DW-1:0]                  rdata_o;
  logic [3:0][DW-1:0]             io_params_o;
  logic [1:0][DW-1:0]             generic_params_o;

  // Operations from the data file, one entry per line
  logic [31:0] grp_q[$];
  logic [31:0] op_q[$];
  logic [31:0] a_q[$];
  logic [31:0] b_q[$];
  logic [31:0] c_q[$];
  logic [31:0] exp_q[$];   // Expected read data, oldest first
  logic [31:0] addr_q[$];
  logic [31:0] exp_word;
  logic [31:0] exp_addr;
  logic [1:0][DW-1:0] gen_model;  // Generic registers as written by the data file
  int          checks    = 0;
  int          errors    = 0;
  int          checks_at = 0;
  int          errors_at = 0;
  int          n_ops     = 0;
  logic        loaded    = 1'b0;

  hwpe_regfile_top hwpe_regfile_top_i (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .clear_i          ( clear_i          ),
    .req_i            ( req_i            ),
    .events_i         ( events_i         ),
    .rvalid_o         ( rvalid_o         ),
    .rdata_o          ( rdata_o          ),
    .io_params_o      ( io_params_o      ),
    .generic_params_o ( generic_params_o )
  );

  always #4 clk_i = ~clk_i;  // 8 ns period

  // Read responses are checked mid-cycle, in request order
  always @(negedge clk_i) begin
    if (rst_ni && rvalid_o) begin
      if (exp_q.size() == 0) begin
        $display("Read response at %0d ns with no read outstanding", $time);
        errors++;
      end else begin
        exp_word = exp_q.pop_front();
        exp_addr = addr_q.pop_front();
        checks++;
        if (rdata_o !== exp_word) begin
          $display("[ERROR] %0d ns: read of %02h returned %h, expected %h",
                   $time, exp_addr, rdata_o, exp_word);
          errors++;
        end
      end
    end
  end

  // Returns the inputs to idle, done is a one-cycle pulse
  task automatic next_cycle();
    @(posedge clk_i);
    req_i         <= '0;
    clear_i       <= 1'b0;
    events_i.done <= 1'b0;
  endtask

  // Merges a write into the expected generic registers, context ignored
  task automatic track_generic_write(input logic [31:0] addr, be, data);
    if (addr[4:3] == hwpe_regfile_pkg::REGION_GENERIC && addr[2:0] < 3'd2) begin
      for (int k = 0; k < 4; k++) begin
        if (be[k]) gen_model[addr[0]][8*k +: 8] = data[8*k +: 8];
      end
    end
  endtask

  task automatic check_generic_params();
    for (int g = 0; g < 2; g++) begin
      checks++;
      if (generic_params_o[g] !== gen_model[g]) begin
        $display("[ERROR] %0d ns: generic_params_o[%0d] is %h, expected %h",
                 $time, g, generic_params_o[g], gen_model[g]);
        errors++;
      end
    end
  endtask

  task automatic run_op(input logic [31:0] op, a, b, c);
    case (op)
      32'd1: begin
        next_cycle();
        req_i.req   <= 1'b1;
        req_i.we    <= 1'b1;
        req_i.addr  <= a;
        req_i.be    <= b[3:0];
        req_i.wdata <= c;
        track_generic_write(a, b, c);
      end
      32'd2: begin
        next_cycle();
        req_i.req  <= 1'b1;
        req_i.addr <= a;
        req_i.be   <= 4'hF;
        exp_q.push_back(b);
        addr_q.push_back(a);
      end
      32'd3: begin
        next_cycle();
        events_i <= hwpe_regfile_pkg::job_events_t'(a[6:0]);
      end
      32'd4: repeat (a) next_cycle();
      32'd5: begin
        next_cycle();
        clear_i   <= 1'b1;
        gen_model = '0;
      end
      32'd6: begin
        next_cycle();
        @(negedge clk_i);
        checks++;
        if (io_params_o[a[1:0]] !== b) begin
          $display("[ERROR] %0d ns: io_params_o[%0d] is %h, expected %h",
                   $time, a[1:0], io_params_o[a[1:0]], b);
          errors++;
        end
        check_generic_params();
      end
      default: begin
        $display("Unknown operation %0h in the test data", op);
        errors++;
      end
    endcase
  endtask

  // Waits for all reads of the group, then reports it
  task automatic close_group(input logic [31:0] grp);
    next_cycle();
    while (exp_q.size() != 0) @(negedge clk_i);
    $display("Group %0d finished: %0d checks, %0d errors",
             grp, checks - checks_at, errors - errors_at);
    checks_at = checks;
    errors_at = errors;
  endtask

  initial begin
    int          fd;
    int          got;
    int          n_fields;
    string       line;
    logic [31:0] grp, op, a, b, c;
    logic [31:0] cur_grp;
    int          assert_fails;

    rst_ni    = 1'b0;
    clear_i   = 1'b0;
    req_i     = '0;
    events_i  = '0;
    gen_model = '0;
    fd = $fopen("test/hwpe_regfile_testdata.txt", "r");
    if (fd == 0) begin
      $display("Cannot open test/hwpe_regfile_testdata.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        got  = $fgets(line, fd);
        if (got != 0 && line.len() > 0 && line[0] != "#") begin
          n_fields = $sscanf(line, "%h %h %h %h %h", grp, op, a, b, c);
          if (n_fields == 5) begin
            grp_q.push_back(grp);
            op_q.push_back(op);
            a_q.push_back(a);
            b_q.push_back(b);
            c_q.push_back(c);
          end else if (n_fields > 0) begin
            $display("Malformed test data line: %s", line);
            errors++;
          end
        end
      end
      $fclose(fd);
    end
    n_ops  = grp_q.size();
    loaded = 1'b1;

    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;

    cur_grp = (n_ops > 0) ? grp_q[0] : '0;
    for (int i = 0; i < n_ops; i++) begin
      if (grp_q[i] != cur_grp) begin
        close_group(cur_grp);
        cur_grp = grp_q[i];
      end
      run_op(op_q[i], a_q[i], b_q[i], c_q[i]);
    end
    if (n_ops > 0) close_group(cur_grp);

    assert_fails = hwpe_regfile_top_i.hwpe_regfile_assertions_i.fail_count;
    errors += assert_fails;
    $display("Total: %0d checks, %0d errors, %0d assertion failures",
             checks, errors, assert_fails);
    if (errors == 0 && checks > 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog, scaled by the number of operations
  initial begin
    wait (loaded);
    repeat ((n_ops + 2) * CYCLES_PER_OP) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d cycles",
             (n_ops + 2) * CYCLES_PER_OP);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* test/hwpe_regfile_assertions.sv */
// Protocol assertions for the HWPE register file
// Read responses follow each read by two cycles, never repeat and carry
// known data

`timescale 1ns/100ps

module hwpe_regfile_assertions (
  input logic                                clk_i,
  input logic                                rst_ni,
  input logic                                clear_i,
  input hwpe_regfile_pkg::regfile_req_t      req_i,
  input logic                                rvalid_i,
  input logic [hwpe_regfile_pkg::DATA_W-1:0] rdata_i
);

  int   fail_count = 0;
  logic read_req;

  assign read_req = req_i.req & ~req_i.we;

  // A clear in flight drops the read
  rvalid_after_read: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    $past(read_req, 2) && !$past(clear_i) && !$past(clear_i, 2) |-> rvalid_i)
    else begin
      fail_count++;
      $error("rvalid_o missing two cycles after a read request");
    end

  rvalid_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_i |-> $past(read_req, 2))
    else begin
      fail_count++;
      $error("rvalid_o high without a read request two cycles earlier");
    end

  rdata_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_i |-> !$isunknown(rdata_i))
    else begin
      fail_count++;
      $error("rdata_o has unknown bits during rvalid_o");
    end

endmodule

bind hwpe_regfile_top hwpe_regfile_assertions hwpe_regfile_assertions_i (
  .clk_i    ( clk_i    ),
  .rst_ni   ( rst_ni   ),
  .clear_i  ( clear_i  ),
  .req_i    ( req_i    ),
  .rvalid_i ( rvalid_o ),
  .rdata_i  ( rdata_o  )
);

/* design/hwpe_regfile_top.sv */
// HWPE control register file, top level
// Address decode, job tracker, parameter bank and read response mux

`timescale 1ns/100ps

module hwpe_regfile_top #(
  parameter int unsigned N_CONTEXT      = 2,
  parameter int unsigned N_IO_REGS      = 4,
  parameter int unsigned N_GENERIC_REGS = 2
) (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  input  logic                                                    clear_i,
  input  hwpe_regfile_pkg::regfile_req_t                          req_i,
  input  hwpe_regfile_pkg::job_events_t                           events_i,
  output logic                                                    rvalid_o,
  output logic [hwpe_regfile_pkg::DATA_W-1:0]                     rdata_o,
  output logic [N_IO_REGS-1:0][hwpe_regfile_pkg::DATA_W-1:0]      io_params_o,
  output logic [N_GENERIC_REGS-1:0][hwpe_regfile_pkg::DATA_W-1:0] generic_params_o
);

  hwpe_regfile_pkg::access_t           access;
  logic [hwpe_regfile_pkg::DATA_W-1:0] tracker_rdata;
  logic                                tracker_owns;
  logic [hwpe_regfile_pkg::DATA_W-1:0] bank_rdata;

  regfile_addr_decode regfile_addr_decode_i (
    .clk_i    ( clk_i   ),
    .rst_ni   ( rst_ni  ),
    .clear_i  ( clear_i ),
    .req_i    ( req_i   ),
    .access_o ( access  )
  );

  job_tracker #(
    .N_CONTEXT ( N_CONTEXT )
  ) job_tracker_i (
    .clk_i       ( clk_i         ),
    .rst_ni      ( rst_ni        ),
    .clear_i     ( clear_i       ),
    .access_i    ( access        ),
    .events_i    ( events_i      ),
    .rdata_o     ( tracker_rdata ),
    .owns_read_o ( tracker_owns  )
  );

  param_bank #(
    .N_CONTEXT      ( N_CONTEXT      ),
    .N_IO_REGS      ( N_IO_REGS      ),
    .N_GENERIC_REGS ( N_GENERIC_REGS )
  ) param_bank_i (
    .clk_i             ( clk_i                ),
    .rst_ni            ( rst_ni               ),
    .clear_i           ( clear_i              ),
    .access_i          ( access               ),
    .running_context_i ( events_i.running_ctx ),
    .rdata_o           ( bank_rdata           ),
    .io_params_o       ( io_params_o          ),
    .generic_params_o  ( generic_params_o     )
  );

  read_mux read_mux_i (
    .clk_i           ( clk_i         ),
    .rst_ni          ( rst_ni        ),
    .clear_i         ( clear_i       ),
    .access_i        ( access        ),
    .tracker_rdata_i ( tracker_rdata ),
    .tracker_owns_i  ( tracker_owns  ),
    .bank_rdata_i    ( bank_rdata    ),
    .rvalid_o        ( rvalid_o      ),
    .rdata_o         ( rdata_o       )
  );

endmodule

/* design/read_mux.sv */
// Read response stage of the HWPE register file
// Forms the one-cycle read valid pulse and picks the tracker or bank word

`timescale 1ns/100ps

module read_mux (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                clear_i,
  input  hwpe_regfile_pkg::access_t           access_i,
  input  logic [hwpe_regfile_pkg::DATA_W-1:0] tracker_rdata_i,
  input  logic                                tracker_owns_i,
  input  logic [hwpe_regfile_pkg::DATA_W-1:0] bank_rdata_i,
  output logic                                rvalid_o,
  output logic [hwpe_regfile_pkg::DATA_W-1:0] rdata_o
);

  logic rvalid_q;

  // Aligned with the registered read words
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else if (clear_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= access_i.read;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = tracker_owns_i ? tracker_rdata_i : bank_rdata_i;  // Tracker claims first

endmodule

/* design/param_bank.sv */
// Parameter bank of the HWPE register file
// Global generic registers plus per-context job registers with byte-enable
// writes; the running context's job registers drive the engine parameters

`timescale 1ns/100ps

module param_bank #(
  parameter int unsigned N_CONTEXT      = 2,
  parameter int unsigned N_IO_REGS      = 4,
  parameter int unsigned N_GENERIC_REGS = 2
) (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  input  logic                                                    clear_i,
  input  hwpe_regfile_pkg::access_t                               access_i,
  input  logic [hwpe_regfile_pkg::CTX_W-1:0]                      running_context_i,
  output logic [hwpe_regfile_pkg::DATA_W-1:0]                     rdata_o,
  output logic [N_IO_REGS-1:0][hwpe_regfile_pkg::DATA_W-1:0]      io_params_o,
  output logic [N_GENERIC_REGS-1:0][hwpe_regfile_pkg::DATA_W-1:0] generic_params_o
);

  localparam int unsigned DW = hwpe_regfile_pkg::DATA_W;
  localparam int unsigned RW = hwpe_regfile_pkg::REG_W;
  localparam logic [RW-1:0] JOB_BASE = {hwpe_regfile_pkg::REGION_JOB, 3'b000};

  hwpe_regfile_pkg::regfile_addr_u          addr;
  logic [RW-1:0]                            job_slot;
  logic                                     gen_hit;
  logic                                     job_hit;
  logic [N_GENERIC_REGS-1:0][DW-1:0]        gen_q;
  logic [N_CONTEXT-1:0][N_IO_REGS-1:0][DW-1:0] job_q;
  logic [DW-1:0]                            rdata_q;

  // Rebuild the word address, job slots come from the flat index
  assign addr     = {access_i.ctx, access_i.region, access_i.offset};
  assign job_slot = addr.flat.reg_idx - JOB_BASE;

  assign gen_hit = access_i.region == hwpe_regfile_pkg::REGION_GENERIC &&
                   access_i.offset < N_GENERIC_REGS;   // Context ignored
  assign job_hit = access_i.region == hwpe_regfile_pkg::REGION_JOB &&
                   job_slot < N_IO_REGS && addr.flat.ctx < N_CONTEXT;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gen_q <= '0;
      job_q <= '0;
    end else if (clear_i) begin
      gen_q <= '0;
      job_q <= '0;
    end else if (access_i.write) begin
      for (int b = 0; b < DW / 8; b++) begin
        if (access_i.be[b]) begin
          if (gen_hit) gen_q[access_i.offset][8*b +: 8] <= access_i.wdata[8*b +: 8];
          if (job_hit) job_q[addr.flat.ctx][job_slot][8*b +: 8] <= access_i.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access_i.read) begin
      if (gen_hit)      rdata_q <= gen_q[access_i.offset];
      else if (job_hit) rdata_q <= job_q[addr.flat.ctx][job_slot];
      else              rdata_q <= hwpe_regfile_pkg::UNMAPPED_DATA;
    end
  end

  // Out-of-range running context gives zero parameters
  assign io_params_o      = (running_context_i < N_CONTEXT) ? job_q[running_context_i] : '0;
  assign generic_params_o = gen_q;
  assign rdata_o          = rdata_q;

endmodule

/* design/job_tracker.sv */
// Job tracker for the HWPE register file
// Offload and running job ids, per-context status bytes, the saturating
// finished counter and all mandatory-region read responses

`timescale 1ns/100ps

module job_tracker #(
  parameter int unsigned N_CONTEXT = 2
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                clear_i,
  input  hwpe_regfile_pkg::access_t           access_i,
  input  hwpe_regfile_pkg::job_events_t       events_i,
  output logic [hwpe_regfile_pkg::DATA_W-1:0] rdata_o,
  output logic                                owns_read_o
);

  localparam int unsigned DW = hwpe_regfile_pkg::DATA_W;

  logic                        is_mandatory;
  logic                        is_acquire;
  logic                        acquire_rd;
  logic                        trigger;
  logic                        finished_rd;
  logic                        grant;       // Acquire read that hands out an id
  logic [7:0]                  offload_id_q;
  logic [7:0]                  running_id_q;
  logic                        done_q;
  logic [1:0]                  finished_cnt_q;
  logic [N_CONTEXT-1:0][7:0]   status_q;
  logic [DW-1:0]               status_word;
  logic [DW-1:0]               rdata_d;
  logic [DW-1:0]               rdata_q;
  logic                        owns_q;

  assign is_mandatory = access_i.region == hwpe_regfile_pkg::REGION_MANDATORY;
  assign is_acquire   = is_mandatory && access_i.offset == hwpe_regfile_pkg::REG_ACQUIRE;
  assign acquire_rd   = access_i.read & is_acquire;   // Test-and-set
  assign trigger      = access_i.write & is_acquire;
  assign finished_rd  = access_i.read & is_mandatory &
                        (access_i.offset == hwpe_regfile_pkg::REG_FINISHED);
  assign grant        = acquire_rd & ~events_i.critical & ~events_i.full;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offload_id_q   <= '0;
      running_id_q   <= '0;
      done_q         <= 1'b0;
      finished_cnt_q <= '0;
      status_q       <= '0;
    end else if (clear_i) begin
      offload_id_q   <= '0;
      running_id_q   <= '0;
      done_q         <= 1'b0;
      finished_cnt_q <= '0;
      status_q       <= '0;
    end else begin
      if (grant) offload_id_q <= offload_id_q + 8'd1;
      done_q <= events_i.done;
      if (done_q) running_id_q <= running_id_q + 8'd1;  // One cycle behind done

      // Read clears, saturates at two
      if (finished_rd) begin
        finished_cnt_q <= '0;
      end else if (events_i.done && finished_cnt_q < 2'd2) begin
        finished_cnt_q <= finished_cnt_q + 2'd1;
      end

      for (int c = 0; c < N_CONTEXT; c++) begin
        if (trigger && events_i.pointer_ctx == c) begin
          status_q[c] <= 8'h01;  // Trigger wins over done
        end else if (events_i.done && events_i.running_ctx == c) begin
          status_q[c] <= 8'h00;
        end
      end
    end
  end

  always_comb begin
    status_word = '0;
    status_word[8*N_CONTEXT-1:0] = status_q;
  end

  always_comb begin
    rdata_d = hwpe_regfile_pkg::UNMAPPED_DATA;
    if (is_mandatory) begin
      case (access_i.offset)
        hwpe_regfile_pkg::REG_ACQUIRE: begin
          if (events_i.critical)  rdata_d = hwpe_regfile_pkg::RESP_OTHER_OFFLOADING;
          else if (events_i.full) rdata_d = hwpe_regfile_pkg::RESP_ALL_CTX_BUSY;
          else                    rdata_d = {{(DW-8){1'b0}}, offload_id_q};
        end
        hwpe_regfile_pkg::REG_FINISHED:    rdata_d = {{(DW-2){1'b0}}, finished_cnt_q};
        hwpe_regfile_pkg::REG_STATUS:      rdata_d = status_word;
        hwpe_regfile_pkg::REG_RUNNING_JOB: rdata_d = {{(DW-8){1'b0}}, running_id_q};
        default:                           rdata_d = hwpe_regfile_pkg::UNMAPPED_DATA;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (access_i.read) rdata_q <= rdata_d;
  end

  // Mandatory and unmapped regions are answered here
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      owns_q <= 1'b0;
    end else if (clear_i) begin
      owns_q <= 1'b0;
    end else if (access_i.read) begin
      owns_q <= is_mandatory || access_i.region == hwpe_regfile_pkg::REGION_UNMAPPED;
    end
  end

  assign rdata_o     = rdata_q;
  assign owns_read_o = owns_q;

endmodule

/* design/regfile_addr_decode.sv */
// Register file address decoder
// Splits each bus request by region and registers it as one access
// descriptor, so all consumers see the same aligned access

`timescale 1ns/100ps

module regfile_addr_decode (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           clear_i,
  input  hwpe_regfile_pkg::regfile_req_t req_i,
  output hwpe_regfile_pkg::access_t      access_o
);

  hwpe_regfile_pkg::regfile_addr_u addr;
  hwpe_regfile_pkg::access_t       access_d;
  hwpe_regfile_pkg::access_t       access_q;

  assign addr = req_i.addr[hwpe_regfile_pkg::ADDR_W-1:0];  // Upper address bits ignored

  always_comb begin
    access_d.read   = req_i.req & ~req_i.we;  // No request, no access
    access_d.write  = req_i.req & req_i.we;
    access_d.region = addr.by_region.region;
    access_d.offset = addr.by_region.offset;
    access_d.ctx    = addr.by_region.ctx;
    access_d.be     = req_i.be;
    access_d.wdata  = req_i.wdata;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      access_q <= '0;
    end else if (clear_i) begin
      access_q <= '0;
    end else begin
      access_q <= access_d;
    end
  end

  assign access_o = access_q;

endmodule

/* design/hwpe_regfile_pkg.sv */
// HWPE register file package
// Bus widths, register map, response codes and the structs shared by the
// address decoder, job tracker, parameter bank and read mux

package hwpe_regfile_pkg;

  localparam int unsigned DATA_W   = 32;
  localparam int unsigned BE_W     = DATA_W / 8;
  localparam int unsigned REG_W    = 5;  // 32 word slots per context
  localparam int unsigned CTX_W    = 2;  // Up to four contexts
  localparam int unsigned ADDR_W   = REG_W + CTX_W;
  localparam int unsigned REGION_W = 2;
  localparam int unsigned OFFSET_W = REG_W - REGION_W;

  // Mandatory register offsets
  localparam logic [OFFSET_W-1:0] REG_ACQUIRE     = 3'd0;
  localparam logic [OFFSET_W-1:0] REG_FINISHED    = 3'd2;
  localparam logic [OFFSET_W-1:0] REG_STATUS      = 3'd3;
  localparam logic [OFFSET_W-1:0] REG_RUNNING_JOB = 3'd4;

  // Upper two bits of the register index
  localparam logic [REGION_W-1:0] REGION_MANDATORY = 2'd0;
  localparam logic [REGION_W-1:0] REGION_GENERIC   = 2'd1;
  localparam logic [REGION_W-1:0] REGION_JOB       = 2'd2;
  localparam logic [REGION_W-1:0] REGION_UNMAPPED  = 2'd3;

  localparam logic [DATA_W-1:0] RESP_OTHER_OFFLOADING = 32'hFFFF_FFFE;  // -2
  localparam logic [DATA_W-1:0] RESP_ALL_CTX_BUSY     = 32'hFFFF_FFFF;  // -1
  localparam logic [DATA_W-1:0] UNMAPPED_DATA         = 32'hDEAD_BEEF;

  typedef struct packed {
    logic [CTX_W-1:0] ctx;
    logic [REG_W-1:0] reg_idx;
  } addr_flat_t;

  typedef struct packed {
    logic [CTX_W-1:0]    ctx;
    logic [REGION_W-1:0] region;
    logic [OFFSET_W-1:0] offset;
  } addr_region_t;

  // Same 7-bit word address, seen flat or split by region
  typedef union packed {
    addr_flat_t   flat;
    addr_region_t by_region;
  } regfile_addr_u;

  typedef struct packed {
    logic              req;    // Single-cycle strobe
    logic              we;
    logic [DATA_W-1:0] addr;   // Word address, low ADDR_W bits decoded
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] wdata;
  } regfile_req_t;

  // Engine controller events
  typedef struct packed {
    logic             done;
    logic             full;
    logic             critical;
    logic [CTX_W-1:0] running_ctx;
    logic [CTX_W-1:0] pointer_ctx;
  } job_events_t;

  typedef struct packed {
    logic                read;
    logic                write;
    logic [REGION_W-1:0] region;
    logic [OFFSET_W-1:0] offset;
    logic [CTX_W-1:0]    ctx;
    logic [BE_W-1:0]     be;
    logic [DATA_W-1:0]   wdata;
  } access_t;

endpackage
